//--- sigma_delta_processor.f
+incdir+source
source/sd_filter_pkg.sv
source/sd_control_pkg.sv
source/sd_timing_if.sv
source/sd_clock_generator.sv
source/sd_sinc3_channel.sv
source/sd_threshold_registers.sv
source/sd_fault_comparator.sv
source/sd_output_combiner.sv
source/sigma_delta_processor.sv
verification/sd_processor_tb.sv

//--- Bender.yml
package:
  name: sigma_delta_processor

sources:
  - include_dirs:
      - source
    files:
      - source/sd_filter_pkg.sv
      - source/sd_control_pkg.sv
      - source/sd_timing_if.sv
      - source/sd_clock_generator.sv
      - source/sd_sinc3_channel.sv
      - source/sd_threshold_registers.sv
      - source/sd_fault_comparator.sv
      - source/sd_output_combiner.sv
      - source/sigma_delta_processor.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/sd_processor_tb.sv

//--- verification/sd_processor_tb.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sd_processor_tb;

    localparam int N = `SD_N_CHANNELS;
    localparam int CLOCK_PERIOD = 100;
    localparam int RANDOM_BURSTS = 16;
    localparam int SYNC_BURSTS = 3;
    localparam int FAULT_BURSTS = 3;
    localparam int PLANNED_PERIODS = RANDOM_BURSTS + SYNC_BURSTS + 3 * FAULT_BURSTS;
    // Twice the planned main periods in ns
    localparam longint WATCHDOG_NS =
        2 * PLANNED_PERIODS * `SD_MAIN_DECIMATION * `SD_CLOCK_DIVIDER * CLOCK_PERIOD;

    // Bit stream patterns
    localparam int MODE_RANDOM = 0;
    localparam int MODE_ONES = 1;
    localparam int MODE_HALF = 2;
    localparam int MODE_ZEROS = 3;

    logic clock;
    logic rst_n;
    logic enable;
    logic sync;
    logic [N-1:0] data_in;
    logic reg_write;
    sd_control_pkg::reg_address_t reg_address;
    sd_control_pkg::threshold_t reg_wdata;
    logic clock_out;
    logic out_valid;
    sd_filter_pkg::channel_id_t out_channel;
    sd_filter_pkg::main_result_t out_data;
    logic [N-1:0] fault;

    // Stimulus state
    int mode;
    logic prev_clock_out;
    logic alternate_bit = 1'b0;

    // Reference model state
    // Integrators wrap at 32 bits and are masked later
    int unsigned acc_1 [N];
    int unsigned acc_2 [N];
    int unsigned acc_3 [N];
    int unsigned main_history [N][3];
    int unsigned comp_history [N][3];
    int main_phase = 0;
    int comparator_phase = 0;
    int main_decimations = 0;
    bit sync_pending = 1'b0;
    int unsigned low_limit [N];
    int unsigned high_limit [N];
    int unsigned comp_last0 = 0;
    int comp_stable = 0;
    logic [N-1:0] fault_expected = '0;
    int fault_delay = 0;

    // Expected main results in output order
    int unsigned exp_data [$];
    int exp_channel [$];
    longint exp_cycle [$];

    longint cycle = 0;
    int value_errors = 0;
    int other_errors = 0;
    string phase_name = "reset_state";

    sigma_delta_processor i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .sync        (sync),
        .data_in     (data_in),
        .reg_write   (reg_write),
        .reg_address (reg_address),
        .reg_wdata   (reg_wdata),
        .clock_out   (clock_out),
        .out_valid   (out_valid),
        .out_channel (out_channel),
        .out_data    (out_data),
        .fault       (fault)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Third order difference of the last integrator at decimation instants
    function automatic int unsigned sinc3_reference(input int unsigned now,
                                                    input int unsigned back_1,
                                                    input int unsigned back_2,
                                                    input int unsigned back_3,
                                                    input int width);
        int unsigned full;
        full = now - 3 * back_1 + 3 * back_2 - back_3;
        return full & ((32'd1 << width) - 1);
    endfunction

    function automatic logic [N-1:0] next_bits(input int pattern, input logic phase);
        case (pattern)
            MODE_ONES: return '1;
            MODE_HALF: return {N{phase}};
            MODE_ZEROS: return '0;
            default: return N'($urandom);
        endcase
    endfunction

    // One modulator sample per rising clock_out
    always @(posedge clock_out) begin : sample_model
        int unsigned value;
        if (sync_pending) begin
            main_phase = 0;
            sync_pending = 1'b0;
        end
        main_phase++;
        comparator_phase++;
        for (int n = 0; n < N; n++) begin
            acc_1[n] += data_in[n];
            acc_2[n] += acc_1[n];
            acc_3[n] += acc_2[n];
        end
        if (main_phase == `SD_MAIN_DECIMATION) begin
            main_phase = 0;
            main_decimations++;
            for (int n = 0; n < N; n++) begin
                value = sinc3_reference(acc_3[n], main_history[n][0], main_history[n][1],
                                        main_history[n][2], `SD_MAIN_WIDTH);
                exp_data.push_back(value);
                exp_channel.push_back(n);
                // Filter, capture and FSM stages before channel 0 shows
                exp_cycle.push_back(cycle + 3 + n);
                main_history[n][2] = main_history[n][1];
                main_history[n][1] = main_history[n][0];
                main_history[n][0] = acc_3[n];
            end
        end
        if (comparator_phase == `SD_COMPARATOR_DECIMATION) begin
            comparator_phase = 0;
            for (int n = 0; n < N; n++) begin
                value = sinc3_reference(acc_3[n], comp_history[n][0], comp_history[n][1],
                                        comp_history[n][2], `SD_COMPARATOR_WIDTH);
                fault_expected[n] = (value > high_limit[n]) || (value < low_limit[n]);
                comp_history[n][2] = comp_history[n][1];
                comp_history[n][1] = comp_history[n][0];
                comp_history[n][0] = acc_3[n];
                if (n == 0) begin
                    comp_stable = (value == comp_last0) ? comp_stable + 1 : 0;
                    comp_last0 = value;
                end
            end
            fault_delay = 3;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////////////////////////

    // New bits right after the modulator clock falls
    always @(posedge clock) begin : drive_data
        prev_clock_out <= clock_out;
        if (prev_clock_out === 1'b1 && clock_out === 1'b0) begin
            alternate_bit <= !alternate_bit;
            data_in <= next_bits(mode, alternate_bit);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    always @(posedge clock) begin : compare_outputs
        int channel;
        cycle++;
        if (out_valid === 1'b1) begin
            if (exp_data.size() == 0) begin
                $display("Main result for channel %0d arrived with none expected", out_channel);
                other_errors++;
            end else begin
                channel = exp_channel.pop_front();
                check_value({phase_name, " channel"}, channel, out_channel);
                check_value($sformatf("%s data ch%0d", phase_name, channel),
                            exp_data.pop_front(), out_data);
                check_value({phase_name, " burst cycle"}, exp_cycle.pop_front(), cycle);
            end
        end
        // Fault level lands one cycle after the comparator result
        if (fault_delay > 0) begin
            fault_delay--;
            if (fault_delay == 0) begin
                check_value({phase_name, " fault"}, fault_expected, fault);
            end
        end
    end

    task automatic write_register(input int address, input int value);
        @(posedge clock);
        reg_write <= 1'b1;
        reg_address <= sd_control_pkg::reg_address_t'(address);
        reg_wdata <= sd_control_pkg::threshold_t'(value);
        if (address < 2 * N) begin
            if (address % 2 == 0) begin
                low_limit[address / 2] = value;
            end else begin
                high_limit[address / 2] = value;
            end
        end
        @(posedge clock);
        reg_write <= 1'b0;
    endtask

    task automatic wait_clock_out_fall();
        do begin
            @(posedge clock);
        end while (!(prev_clock_out === 1'b1 && clock_out === 1'b0));
    endtask

    task automatic wait_for_decimations(input int count);
        int target;
        target = main_decimations + count;
        while (main_decimations < target) begin
            @(posedge clock);
        end
    endtask

    // Steady pattern until the comparator value holds for three periods
    task automatic run_fault_pattern(input string name, input int pattern,
                                     input logic fault_level);
        phase_name = name;
        mode = pattern;
        comp_stable = 0;
        while (comp_stable < 3) begin
            @(posedge clock);
        end
        check_value({name, " fault0"}, fault_level, fault[0]);
    endtask

    initial begin : run_tests
        clock = 1'b0;
        rst_n = 1'b0;
        enable = 1'b0;
        sync = 1'b0;
        data_in = '0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_wdata = '0;
        mode = MODE_RANDOM;
        void'($urandom(58156));
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;

        // Everything quiet while disabled
        repeat (8) begin
            @(posedge clock);
            check_value("reset_state out_valid", 0, out_valid);
            check_value("reset_state clock_out", 0, clock_out);
            check_value("reset_state fault", 0, fault);
        end

        // Channel 0 window 10..50, channel 1 window 20..100
        write_register(0, 10);
        write_register(1, 50);
        write_register(2, 20);
        write_register(3, 100);
        // Addresses past the last channel must not land anywhere
        write_register(2 * N, 127);
        write_register(2 * N + 3, 77);

        // Random streams
        // First bursts include the wraparound after reset
        phase_name = "random_stream";
        @(posedge clock);
        enable <= 1'b1;
        wait_for_decimations(RANDOM_BURSTS);

        // Sync mid period
        phase_name = "sync";
        do begin
            wait_clock_out_fall();
        end while (main_phase != 7);
        sync <= 1'b1;
        sync_pending = 1'b1;
        @(posedge clock);
        sync <= 1'b0;
        wait_for_decimations(SYNC_BURSTS);

        // Full scale 64 lies above the window
        run_fault_pattern("fault_ones", MODE_ONES, 1'b1);
        // Half density 32 lies inside
        run_fault_pattern("fault_half", MODE_HALF, 1'b0);
        // Zero lies below
        run_fault_pattern("fault_zeros", MODE_ZEROS, 1'b1);

        // Let the last bursts and fault updates drain
        enable <= 1'b0;
        do begin
            @(negedge clock);
        end while (exp_data.size() != 0 || fault_delay != 0);

        $display("Error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- source/sigma_delta_processor.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sigma_delta_processor (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    input  logic sync,
    input  logic [`SD_N_CHANNELS-1:0] data_in,
    input  logic reg_write,
    input  sd_control_pkg::reg_address_t reg_address,
    input  sd_control_pkg::threshold_t reg_wdata,
    output logic clock_out,
    output logic out_valid,
    output sd_filter_pkg::channel_id_t out_channel,
    output sd_filter_pkg::main_result_t out_data,
    output logic [`SD_N_CHANNELS-1:0] fault
);

    sd_timing_if timing ();

    sd_filter_pkg::main_result_t main_results [`SD_N_CHANNELS];
    logic [`SD_N_CHANNELS-1:0] main_valid;
    sd_filter_pkg::comparator_result_t comparator_results [`SD_N_CHANNELS];
    logic [`SD_N_CHANNELS-1:0] comparator_valid;
    sd_control_pkg::threshold_t low_threshold [`SD_N_CHANNELS];
    sd_control_pkg::threshold_t high_threshold [`SD_N_CHANNELS];

    //////////////////////////////////////////////////////////////////////
    // Clock and strobes
    //////////////////////////////////////////////////////////////////////

    sd_clock_generator clock_generator (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .sync   (sync),
        .timing (timing.generator)
    );

    // Modulators run from this level
    assign clock_out = timing.sd_clock;

    //////////////////////////////////////////////////////////////////////
    // Filters
    //////////////////////////////////////////////////////////////////////

    // Both decimators of a channel see the same bit stream
    for (genvar i = 0; i < `SD_N_CHANNELS; i++) begin : gen_channel
        sd_sinc3_channel #(
            .DECIMATION_SOURCE (1'b0),
            .RESULT_WIDTH      (`SD_MAIN_WIDTH)
        ) main_filter (
            .clock        (clock),
            .rst_n        (rst_n),
            .data_bit     (data_in[i]),
            .timing       (timing.channel),
            .result       (main_results[i]),
            .result_valid (main_valid[i])
        );

        sd_sinc3_channel #(
            .DECIMATION_SOURCE (1'b1),
            .RESULT_WIDTH      (`SD_COMPARATOR_WIDTH)
        ) comparator_filter (
            .clock        (clock),
            .rst_n        (rst_n),
            .data_bit     (data_in[i]),
            .timing       (timing.channel),
            .result       (comparator_results[i]),
            .result_valid (comparator_valid[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Fault detection and output
    //////////////////////////////////////////////////////////////////////

    sd_threshold_registers threshold_registers (
        .clock          (clock),
        .rst_n          (rst_n),
        .reg_write      (reg_write),
        .reg_address    (reg_address),
        .reg_wdata      (reg_wdata),
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold)
    );

    sd_fault_comparator fault_comparator (
        .clock          (clock),
        .rst_n          (rst_n),
        .results        (comparator_results),
        .result_valid   (comparator_valid),
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold),
        .fault          (fault)
    );

    sd_output_combiner output_combiner (
        .clock        (clock),
        .rst_n        (rst_n),
        .results      (main_results),
        .result_valid (main_valid),
        .out_valid    (out_valid),
        .out_channel  (out_channel),
        .out_data     (out_data)
    );

endmodule

//--- source/sd_output_combiner.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sd_output_combiner (
    input  logic clock,
    input  logic rst_n,
    input  sd_filter_pkg::main_result_t results [`SD_N_CHANNELS],
    input  logic [`SD_N_CHANNELS-1:0] result_valid,
    output logic out_valid,
    output sd_filter_pkg::channel_id_t out_channel,
    output sd_filter_pkg::main_result_t out_data
);

    localparam sd_filter_pkg::channel_id_t LAST_CHANNEL =
        sd_filter_pkg::channel_id_t'(`SD_N_CHANNELS - 1);

    sd_control_pkg::combiner_state_t state;
    sd_filter_pkg::channel_id_t emit_index;
    sd_filter_pkg::main_result_t held [`SD_N_CHANNELS];
    logic capture;

    // Main channels decimate together so any valid bit starts a burst
    assign capture = |result_valid;

    //////////////////////////////////////////////////////////////////////
    // Result capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (capture) begin
            for (int n = 0; n < `SD_N_CHANNELS; n++) begin
                held[n] <= results[n];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Burst FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= sd_control_pkg::IDLE;
            emit_index <= '0;
        end else begin
            case (state)
                sd_control_pkg::IDLE: begin
                    emit_index <= '0;
                    if (capture) begin
                        state <= sd_control_pkg::EMIT;
                    end
                end
                sd_control_pkg::EMIT: begin
                    // One channel per cycle, back to idle after the last
                    if (emit_index == LAST_CHANNEL) begin
                        state <= sd_control_pkg::IDLE;
                        emit_index <= '0;
                    end else begin
                        emit_index <= emit_index + 1'b1;
                    end
                end
                default: state <= sd_control_pkg::IDLE;
            endcase
        end
    end

    assign out_valid = (state == sd_control_pkg::EMIT);
    assign out_channel = emit_index;
    assign out_data = held[emit_index];

endmodule

//--- source/sd_fault_comparator.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sd_fault_comparator (
    input  logic clock,
    input  logic rst_n,
    input  sd_filter_pkg::comparator_result_t results [`SD_N_CHANNELS],
    input  logic [`SD_N_CHANNELS-1:0] result_valid,
    input  sd_control_pkg::threshold_t low_threshold [`SD_N_CHANNELS],
    input  sd_control_pkg::threshold_t high_threshold [`SD_N_CHANNELS],
    output logic [`SD_N_CHANNELS-1:0] fault
);

    // Out of window flag per channel
    logic [`SD_N_CHANNELS-1:0] outside;

    always_comb begin
        for (int n = 0; n < `SD_N_CHANNELS; n++) begin
            // Strict compare so a result equal to a limit is still good
            outside[n] = (results[n] > high_threshold[n]) ||
                         (results[n] < low_threshold[n]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fault levels
    //////////////////////////////////////////////////////////////////////

    // Each level follows its own channel and holds between results
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fault <= '0;
        end else begin
            for (int n = 0; n < `SD_N_CHANNELS; n++) begin
                if (result_valid[n]) begin
                    fault[n] <= outside[n];
                end
            end
        end
    end

endmodule

//--- source/sd_threshold_registers.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sd_threshold_registers (
    input  logic clock,
    input  logic rst_n,
    input  logic reg_write,
    input  sd_control_pkg::reg_address_t reg_address,
    input  sd_control_pkg::threshold_t reg_wdata,
    output sd_control_pkg::threshold_t low_threshold [`SD_N_CHANNELS],
    output sd_control_pkg::threshold_t high_threshold [`SD_N_CHANNELS]
);

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    // Even address is the low bound of channel address/2
    // Odd address is the high bound
    // Addresses past the last channel fall through

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int n = 0; n < `SD_N_CHANNELS; n++) begin
                low_threshold[n] <= '0;
                high_threshold[n] <= '0;
            end
        end else if (reg_write) begin
            for (int n = 0; n < `SD_N_CHANNELS; n++) begin
                // Low bound
                if (reg_address == sd_control_pkg::reg_address_t'(2 * n)) begin
                    low_threshold[n] <= reg_wdata;
                end
                // High bound
                if (reg_address == sd_control_pkg::reg_address_t'(2 * n + 1)) begin
                    high_threshold[n] <= reg_wdata;
                end
            end
        end
    end

endmodule

//--- source/sd_sinc3_channel.sv
`timescale 1ns/1ps

module sd_sinc3_channel #(
    // 0 follows main_decimate, 1 follows comparator_decimate
    parameter bit DECIMATION_SOURCE = 1'b0,
    parameter int RESULT_WIDTH = 13
) (
    input  logic clock,
    input  logic rst_n,
    input  logic data_bit,
    sd_timing_if.channel timing,
    output logic [RESULT_WIDTH-1:0] result,
    output logic result_valid
);

    logic decimate;

    logic [RESULT_WIDTH-1:0] integrator_1;
    logic [RESULT_WIDTH-1:0] integrator_2;
    logic [RESULT_WIDTH-1:0] integrator_3;
    logic [RESULT_WIDTH-1:0] sum_1;
    logic [RESULT_WIDTH-1:0] sum_2;
    logic [RESULT_WIDTH-1:0] sum_3;
    logic [RESULT_WIDTH-1:0] integrator_now;

    logic [RESULT_WIDTH-1:0] comb_delay_1;
    logic [RESULT_WIDTH-1:0] comb_delay_2;
    logic [RESULT_WIDTH-1:0] comb_delay_3;
    logic [RESULT_WIDTH-1:0] comb_1;
    logic [RESULT_WIDTH-1:0] comb_2;
    logic [RESULT_WIDTH-1:0] comb_3;

    assign decimate = DECIMATION_SOURCE ? timing.comparator_decimate : timing.main_decimate;

    //////////////////////////////////////////////////////////////////////
    // Integrators
    //////////////////////////////////////////////////////////////////////

    // Cascade settles within one cycle, all sums wrap modulo 2^RESULT_WIDTH
    assign sum_1 = integrator_1 + RESULT_WIDTH'(data_bit);
    assign sum_2 = integrator_2 + sum_1;
    assign sum_3 = integrator_3 + sum_2;

    // Last stage including the sample of this cycle
    assign integrator_now = timing.sample_strobe ? sum_3 : integrator_3;

    //////////////////////////////////////////////////////////////////////
    // Combs
    //////////////////////////////////////////////////////////////////////

    assign comb_1 = integrator_now - comb_delay_1;
    assign comb_2 = comb_1 - comb_delay_2;
    assign comb_3 = comb_2 - comb_delay_3;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            integrator_1 <= '0;
            integrator_2 <= '0;
            integrator_3 <= '0;
            comb_delay_1 <= '0;
            comb_delay_2 <= '0;
            comb_delay_3 <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= decimate;
            if (timing.sample_strobe) begin
                integrator_1 <= sum_1;
                integrator_2 <= sum_2;
                integrator_3 <= sum_3;
            end
            // Comb delays advance at the output rate
            if (decimate) begin
                comb_delay_1 <= integrator_now;
                comb_delay_2 <= comb_1;
                comb_delay_3 <= comb_2;
            end
        end
    end

    // Result is only meaningful with result_valid
    always_ff @(posedge clock) begin
        if (decimate) begin
            result <= comb_3;
        end
    end

endmodule

//--- source/sd_clock_generator.sv
`timescale 1ns/1ps
`include "sd_processor_config.svh"

module sd_clock_generator (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    input  logic sync,
    sd_timing_if.generator timing
);

    localparam int HALF_PERIOD = `SD_CLOCK_DIVIDER / 2;
    localparam int DIV_WIDTH = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
    localparam int MAIN_COUNT_WIDTH = $clog2(`SD_MAIN_DECIMATION);
    localparam int COMP_COUNT_WIDTH = $clog2(`SD_COMPARATOR_DECIMATION);

    logic [DIV_WIDTH-1:0] divider_count;
    logic sd_clock;
    logic sample_strobe;
    logic half_done;
    logic rising_next;
    logic [MAIN_COUNT_WIDTH-1:0] main_count;
    logic [MAIN_COUNT_WIDTH-1:0] main_base;
    logic [COMP_COUNT_WIDTH-1:0] comparator_count;
    logic main_decimate;
    logic comparator_decimate;

    //////////////////////////////////////////////////////////////////////
    // Modulator clock divider
    //////////////////////////////////////////////////////////////////////

    // End of a half period, only counted while enabled
    assign half_done = enable && (divider_count == DIV_WIDTH'(HALF_PERIOD - 1));
    // Next toggle is a rising one
    assign rising_next = half_done && !sd_clock;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            divider_count <= '0;
            sd_clock <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            // Strobe lands in the same cycle as the new high level
            sample_strobe <= rising_next;
            if (half_done) begin
                divider_count <= '0;
                sd_clock <= !sd_clock;
            end else if (enable) begin
                divider_count <= divider_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decimation counters
    //////////////////////////////////////////////////////////////////////

    // Sync restarts the main phase
    // A sample issued in the sync cycle is the first one after it
    assign main_base = sync ? '0 : main_count;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            main_count <= '0;
            comparator_count <= '0;
            main_decimate <= 1'b0;
            comparator_decimate <= 1'b0;
        end else begin
            main_decimate <= 1'b0;
            comparator_decimate <= 1'b0;
            main_count <= main_base;
            if (rising_next) begin
                if (main_base == MAIN_COUNT_WIDTH'(`SD_MAIN_DECIMATION - 1)) begin
                    main_count <= '0;
                    main_decimate <= 1'b1;
                end else begin
                    main_count <= main_base + 1'b1;
                end
                // Free running, sync leaves it alone
                if (comparator_count == COMP_COUNT_WIDTH'(`SD_COMPARATOR_DECIMATION - 1)) begin
                    comparator_count <= '0;
                    comparator_decimate <= 1'b1;
                end else begin
                    comparator_count <= comparator_count + 1'b1;
                end
            end
        end
    end

    assign timing.sd_clock = sd_clock;
    assign timing.sample_strobe = sample_strobe;
    assign timing.main_decimate = main_decimate;
    assign timing.comparator_decimate = comparator_decimate;

endmodule

//--- source/sd_timing_if.sv
`timescale 1ns/1ps

interface sd_timing_if;

    // Modulator clock level
    logic sd_clock;
    // One cycle pulse as sd_clock goes high
    logic sample_strobe;
    // Decimation pulses, each coincident with a sample strobe
    logic main_decimate;
    logic comparator_decimate;

    // Clock generator side
    modport generator (output sd_clock, sample_strobe, main_decimate, comparator_decimate);

    // Filter side
    modport channel (input sd_clock, sample_strobe, main_decimate, comparator_decimate);

endinterface

//--- source/sd_control_pkg.sv
`include "sd_processor_config.svh"

package sd_control_pkg;

    // Threshold register address
    typedef logic [`SD_REG_ADDRESS_WIDTH-1:0] reg_address_t;

    // Fault limit, same scale as the comparator result
    typedef logic [`SD_COMPARATOR_WIDTH-1:0] threshold_t;

    // Output combiner FSM
    // IDLE waits for a main decimation
    // EMIT walks the captured results
    typedef enum logic {
        IDLE,
        EMIT
    } combiner_state_t;

endpackage

//--- source/sd_filter_pkg.sv
`include "sd_processor_config.svh"

package sd_filter_pkg;

    ////////////////////////////////////////////////////////////////////
    // Filter result types
    ////////////////////////////////////////////////////////////////////

    // Full width main decimator output
    typedef logic [`SD_MAIN_WIDTH-1:0] main_result_t;

    // Coarse comparator decimator output
    typedef logic [`SD_COMPARATOR_WIDTH-1:0] comparator_result_t;

    ////////////////////////////////////////////////////////////////////
    // Channel numbering
    ////////////////////////////////////////////////////////////////////

    // At least one bit even for a single channel
    localparam int CHANNEL_ID_WIDTH =
        (`SD_N_CHANNELS > 1) ? $clog2(`SD_N_CHANNELS) : 1;

    // Tag carried with each combined result
    typedef logic [CHANNEL_ID_WIDTH-1:0] channel_id_t;

endpackage

//--- source/sd_processor_config.svh
`ifndef SD_PROCESSOR_CONFIG_SVH
`define SD_PROCESSOR_CONFIG_SVH

// Number of modulator bit streams
`define SD_N_CHANNELS 2

// System clocks per modulator clock period
// Must be even so both clock phases are equal
`define SD_CLOCK_DIVIDER 4

// Decimation ratios in modulator samples
`define SD_MAIN_DECIMATION 16
`define SD_COMPARATOR_DECIMATION 4

// Sinc3 widths are 3*log2(ratio)+1 so full scale fits unsigned
`define SD_MAIN_WIDTH 13
`define SD_COMPARATOR_WIDTH 7

// Threshold register address width
`define SD_REG_ADDRESS_WIDTH 4

`endif
